// File: bench/ilk_tx_cases.txt
# columns: packet length in bytes, error flag, stray beat before packet, ilk_ready stall percent
# all values decimal, one packet per line
1 0 0 0
2 0 0 10
3 0 1 0
4 1 0 0
5 0 0 20
6 0 0 0
7 0 1 15
8 0 0 0
9 0 0 0
10 1 0 25
11 0 0 0
12 0 1 0
13 0 0 30
14 0 0 0
15 0 0 10
16 0 0 0
17 0 1 0
24 0 0 25
31 1 0 0
32 0 1 30
64 0 0 0
65 0 0 40
100 0 1 50
128 0 0 20
135 1 1 35
200 0 0 50
9 1 0 10
16 1 1 0

// File: bench/tb_ilk_tx.sv
/* self-checking testbench for ilk_tx_top, run from the project root
   cases come from bench/ilk_tx_cases.txt, data and ilk_ready stalls from an lcg */

`timescale 1ns/1ps

module tb_ilk_tx;

   logic         clk;
   logic         reset;
   logic [127:0] avl_data;
   logic         avl_sop;
   logic         avl_eop;
   logic [3:0]   avl_empty;
   logic         avl_error;
   logic         avl_valid;
   logic         avl_ready;
   logic [127:0] ilk_data;
   logic [1:0]   ilk_num_valid;
   logic         ilk_sop;
   logic [3:0]   ilk_eopbits;
   logic         ilk_burst_end;
   logic         ilk_valid;
   logic         ilk_ready;
   logic         stray_drop;

   // case table, one entry per packet
   int case_len[$];
   int case_err[$];
   int case_stray[$];
   int case_stall[$];

   // expected beats {data, num_valid, sop, eopbits, burst_end}
   logic [135:0] exp_q[$];

   int unsigned data_seed  = 91516;
   int unsigned stall_seed = 91516;
   int cur_stall   = 0;
   int burst_words = 0;
   int exp_strays  = 0;
   int seen_strays = 0;
   int errors      = 0;
   int checks      = 0;
   int failed      = 0;
   int cycle_count = 0;
   int cycle_limit = 0;

   ilk_tx_top u_dut (
      .clk           (clk),
      .reset         (reset),
      .avl_data      (avl_data),
      .avl_sop       (avl_sop),
      .avl_eop       (avl_eop),
      .avl_empty     (avl_empty),
      .avl_error     (avl_error),
      .avl_valid     (avl_valid),
      .avl_ready     (avl_ready),
      .ilk_data      (ilk_data),
      .ilk_num_valid (ilk_num_valid),
      .ilk_sop       (ilk_sop),
      .ilk_eopbits   (ilk_eopbits),
      .ilk_burst_end (ilk_burst_end),
      .ilk_valid     (ilk_valid),
      .ilk_ready     (ilk_ready),
      .stray_drop    (stray_drop)
   );

   // 40 ns period
   always #20 clk = ~clk;

   function automatic int unsigned lcg_next(input int unsigned s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // four draws fill one 128-bit beat
   function automatic logic [127:0] rand_beat();
      logic [127:0] r;
      r = '0;
      for (int i = 0; i < 4; i++) begin
         data_seed = lcg_next(data_seed);
         r = {r[95:0], data_seed};
      end
      return r;
   endfunction

   // expected output of one kept beat, built from the byte count of the beat
   function automatic logic [135:0] model_beat(input logic [127:0] data, input logic sop,
                                               input logic eop, input logic [3:0] empty,
                                               input logic err);
      int bytes;
      int nv;
      int last_bytes;
      logic [3:0] code;
      logic bend;
      bytes = 16 - empty;
      // second word carries data once more than 8 bytes are used
      nv = (bytes > 8) ? 2 : 1;
      code = 4'b0000;
      if (eop) begin
         // 1 to 8 bytes in the last word, 8 wraps to code 1000
         last_bytes = bytes - 8 * (nv - 1);
         code = err ? 4'b0001 : 4'(8 + (last_bytes % 8));
      end
      if (sop) begin
         burst_words = 0;
      end
      burst_words += nv;
      bend = eop || (burst_words >= 8);
      if (bend) begin
         burst_words = 0;
      end
      return {data, 2'(nv), sop, code, bend};
   endfunction

   task automatic check_val(input string name, input logic [127:0] exp,
                            input logic [127:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("** Error at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
      end
   endtask

   // called at a falling edge, returns at the falling edge after the transfer
   task automatic send_beat(input logic [127:0] data, input logic sop, input logic eop,
                            input logic [3:0] empty, input logic err, input logic stray);
      avl_data  = data;
      avl_sop   = sop;
      avl_eop   = eop;
      avl_empty = empty;
      avl_error = err;
      avl_valid = 1'b1;
      if (stray) begin
         exp_strays++;
      end else begin
         exp_q.push_back(model_beat(data, sop, eop, empty, err));
      end
      // avl_ready is registered, so its value here holds through the next edge
      while (!avl_ready) begin
         @(negedge clk);
      end
      @(negedge clk);
      avl_valid = 1'b0;
   endtask

   task automatic run_case(input int idx, input int len, input int err, input int stray,
                           input int stall);
      int beats;
      int errs_before;
      logic [3:0] empty;
      logic last;
      errs_before = errors;
      // stall level changes away from the falling edge where ilk_ready is drawn
      @(posedge clk);
      cur_stall = stall;
      @(negedge clk);
      // stray beat while no packet is open
      if (stray != 0) begin
         send_beat(rand_beat(), 1'b0, data_seed[7], 4'd0, data_seed[9], 1'b1);
      end
      beats = (len + 15) / 16;
      for (int b = 0; b < beats; b++) begin
         last  = (b == beats - 1);
         empty = last ? 4'(beats * 16 - len) : 4'd0;
         send_beat(rand_beat(), b == 0, last, empty, last && (err != 0), 1'b0);
      end
      // all expected beats must leave before the case ends
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      check_val("stray_drop count", exp_strays, seen_strays);
      if (errors != errs_before) begin
         failed++;
      end
      $display("case %0d: %0d bytes, %0d beats, error %0d, stray %0d, stall %0d%%: %s",
               idx, len, beats, err, stray, stall,
               (errors == errs_before) ? "ok" : "mismatch");
   endtask

   // ilk_ready pattern, redrawn every falling edge
   always @(negedge clk) begin
      stall_seed = lcg_next(stall_seed);
      ilk_ready  = (((stall_seed >> 8) % 100) >= cur_stall);
   end

   // monitor and scoreboard
   always @(posedge clk) begin
      logic [135:0] e;
      if (!reset) begin
         if (stray_drop) begin
            seen_strays++;
         end
         if (ilk_valid && ilk_ready) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("output beat at %0t ns arrived with no beat expected", $time);
            end else begin
               e = exp_q.pop_front();
               check_val("ilk_data", e[135:8], ilk_data);
               check_val("ilk_num_valid", e[7:6], ilk_num_valid);
               check_val("ilk_sop", e[5], ilk_sop);
               check_val("ilk_eopbits", e[4:1], ilk_eopbits);
               check_val("ilk_burst_end", e[0], ilk_burst_end);
            end
         end
      end
   end

   // run limit from the total beat count
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
         $display("timeout after %0d cycles, %0d expected beats never came out",
                  cycle_limit, exp_q.size());
         $display("Testbench failed");
         $finish;
      end
   end

   initial begin
      int fd;
      int n;
      int total_beats;
      int f_len;
      int f_err;
      int f_stray;
      int f_stall;
      string line;
      clk       = 1'b0;
      reset     = 1'b1;
      avl_data  = '0;
      avl_sop   = 1'b0;
      avl_eop   = 1'b0;
      avl_empty = '0;
      avl_error = 1'b0;
      avl_valid = 1'b0;
      ilk_ready = 1'b1;
      total_beats = 0;

      fd = $fopen("bench/ilk_tx_cases.txt", "r");
      if (fd == 0) begin
         $display("cannot open the case file bench/ilk_tx_cases.txt");
         $display("Testbench failed");
         $finish;
      end else begin
         // lines that do not scan as four numbers are comments
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%d %d %d %d", f_len, f_err, f_stray, f_stall) == 4) begin
               case_len.push_back(f_len);
               case_err.push_back(f_err);
               case_stray.push_back(f_stray);
               case_stall.push_back(f_stall);
               total_beats += (f_len + 15) / 16 + ((f_stray != 0) ? 1 : 0);
            end
         end
         $fclose(fd);
         cycle_limit = 4 * total_beats + 200;

         repeat (2) @(posedge clk);
         @(negedge clk);
         reset = 1'b0;
         // state right after reset
         check_val("avl_ready", 1'b1, avl_ready);
         check_val("ilk_valid", 1'b0, ilk_valid);
         check_val("ilk_burst_end", 1'b0, ilk_burst_end);
         check_val("stray_drop", 1'b0, stray_drop);

         for (int i = 0; i < case_len.size(); i++) begin
            run_case(i, case_len[i], case_err[i], case_stray[i], case_stall[i]);
         end
         if (case_len.size() == 0) begin
            errors++;
            $display("the case file holds no usable case line");
         end

         repeat (4) @(negedge clk);
         $display("summary: %0d cases, %0d failed, %0d checks, %0d errors",
                  case_len.size(), failed, checks, errors);
         if (errors == 0) begin
            $display("Testbench passed");
         end else begin
            $display("Testbench failed");
         end
         $finish;
      end
   end

endmodule

// File: source/avl_rx_stage.sv
/* avalon-st input stage, two-entry skid buffer with registered avl_ready
   beats with no sop outside an open packet are accepted and discarded */

`timescale 1ns/1ps

module avl_rx_stage
   import ilk_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   // avalon-st sink
   input  beat_data_t avl_data,
   input  logic       avl_sop,
   input  logic       avl_eop,
   input  empty_t     avl_empty,
   input  logic       avl_error,
   input  logic       avl_valid,
   output logic       avl_ready,
   // towards the adapter
   output beat_data_t rx_data,
   output logic       rx_sop,
   output logic       rx_eop,
   output empty_t     rx_empty,
   output logic       rx_error,
   output logic       rx_valid,
   input  logic       rx_ready,
   // one cycle per discarded stray beat
   output logic       stray_drop
);

   // second entry, only used while the output entry is stalled
   beat_data_t skid_data;
   logic       skid_sop;
   logic       skid_eop;
   empty_t     skid_empty;
   logic       skid_error;
   logic       skid_valid;

   // set between an accepted sop and the matching eop
   logic pkt_open;

   logic in_fire;
   logic in_keep;
   logic in_take;
   logic out_free;
   logic skid_load;
   logic skid_drain;
   logic skid_next;

   always_comb begin
      in_fire  = avl_valid & avl_ready;
      // sop always starts a packet, otherwise the beat needs an open one
      in_keep  = avl_sop | pkt_open;
      in_take  = in_fire & in_keep;
      // output entry can take a new beat this cycle
      out_free = ~rx_valid | rx_ready;
      // skid only fills when a kept beat meets a stalled output entry
      skid_load  = in_take & ~out_free;
      skid_drain = skid_valid & out_free;
      skid_next  = (skid_valid & ~skid_drain) | skid_load;
   end

   // control state
   always_ff @(posedge clk) begin
      if (reset) begin
         rx_valid   <= 1'b0;
         skid_valid <= 1'b0;
         avl_ready  <= 1'b1;
         pkt_open   <= 1'b0;
         stray_drop <= 1'b0;
      end else begin
         stray_drop <= in_fire & ~in_keep;
         if (in_take) begin
            // a single-beat packet opens and closes in the same beat
            pkt_open <= ~avl_eop;
         end
         if (out_free) begin
            rx_valid <= skid_valid | in_take;
         end
         skid_valid <= skid_next;
         // ready low only while both entries hold a beat
         avl_ready  <= ~skid_next;
      end
   end

   // payload, skid entry has priority so order is kept
   always_ff @(posedge clk) begin
      if (out_free) begin
         if (skid_valid) begin
            rx_data  <= skid_data;
            rx_sop   <= skid_sop;
            rx_eop   <= skid_eop;
            rx_empty <= skid_empty;
            rx_error <= skid_error;
         end else if (in_take) begin
            rx_data  <= avl_data;
            rx_sop   <= avl_sop;
            rx_eop   <= avl_eop;
            rx_empty <= avl_empty;
            rx_error <= avl_error;
         end
      end
      if (skid_load) begin
         skid_data  <= avl_data;
         skid_sop   <= avl_sop;
         skid_eop   <= avl_eop;
         skid_empty <= avl_empty;
         skid_error <= avl_error;
      end
   end

endmodule

// File: source/avl_to_ilk_adapter.sv
/* combinational avalon to interlaken beat re-encoding, no storage
   non-eop beats are expected to have empty 0 or 8, other values give 0 words */

`timescale 1ns/1ps

module avl_to_ilk_adapter
   import ilk_pkg::*;
(
   // from the input stage
   input  beat_data_t rx_data,
   input  logic       rx_sop,
   input  logic       rx_eop,
   input  empty_t     rx_empty,
   input  logic       rx_error,
   input  logic       rx_valid,
   output logic       rx_ready,
   // towards the burst stage
   output beat_data_t ad_data,
   output num_valid_t ad_num_valid,
   output logic       ad_sop,
   output eopbits_t   ad_eopbits,
   output logic       ad_valid,
   input  logic       ad_ready
);

   // valid bytes in the last word of an eop beat, 1 to 8
   logic [3:0] last_bytes;

   // handshake and data go straight through
   assign ad_data  = rx_data;
   assign ad_sop   = rx_sop;
   assign ad_valid = rx_valid;
   assign rx_ready = ad_ready;

   // empty counts from the low end, so only the low 3 bits reach the last word
   assign last_bytes = 4'd8 - {1'b0, rx_empty[2:0]};

   always_comb begin
      ad_num_valid = '0;
      ad_eopbits   = eop_none;
      if (rx_valid && !rx_eop) begin
         // mid-packet beat, whole words only
         case (rx_empty)
            4'd0: begin
               ad_num_valid = num_valid_t'(words_per_beat);
            end
            4'd8: begin
               ad_num_valid = num_valid_t'(1);
            end
            default: begin
               // partial word without eop is illegal, mark nothing valid
               ad_num_valid = '0;
            end
         endcase
         ad_eopbits = eop_none;
      end else if (rx_valid) begin
         // eop beat, second word is in use while fewer than 8 bytes are empty
         if (rx_empty < 4'd8) begin
            ad_num_valid = num_valid_t'(words_per_beat);
         end else begin
            ad_num_valid = num_valid_t'(1);
         end
         // error overrides the byte count
         if (rx_error) begin
            ad_eopbits = eop_error;
         end else begin
            // a full last word of 8 bytes wraps to 000
            ad_eopbits = {1'b1, last_bytes[2:0]};
         end
      end
   end

endmodule

// File: source/ilk_burst_stage.sv
/* output register stage, counts words per burst and flags burst ends
   beats with zero valid words are accepted but never presented */

`timescale 1ns/1ps

module ilk_burst_stage
   import ilk_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   // from the adapter
   input  beat_data_t ad_data,
   input  num_valid_t ad_num_valid,
   input  logic       ad_sop,
   input  eopbits_t   ad_eopbits,
   input  logic       ad_valid,
   output logic       ad_ready,
   // interlaken side towards the burst/control word inserter
   output beat_data_t ilk_data,
   output num_valid_t ilk_num_valid,
   output logic       ilk_sop,
   output eopbits_t   ilk_eopbits,
   output logic       ilk_burst_end,
   output logic       ilk_valid,
   input  logic       ilk_ready
);

   // words sent since the last burst end
   burst_count_t burst_cnt;

   logic         ad_fire;
   logic         beat_keep;
   burst_count_t cnt_base;
   burst_count_t cnt_sum;
   logic         burst_end;

   // register is free when empty or being drained this cycle
   assign ad_ready = ~ilk_valid | ilk_ready;

   always_comb begin
      ad_fire   = ad_valid & ad_ready;
      beat_keep = ad_num_valid != '0;
      // sop starts a fresh count regardless of what came before
      cnt_base  = ad_sop ? '0 : burst_cnt;
      cnt_sum   = cnt_base + burst_count_t'(ad_num_valid);
      // a 7 to 9 step with a single-word beat before still ends the burst
      burst_end = (ad_eopbits != eop_none) ||
                  (cnt_sum >= burst_count_t'(burst_max_words));
   end

   // control state
   always_ff @(posedge clk) begin
      if (reset) begin
         ilk_valid     <= 1'b0;
         ilk_burst_end <= 1'b0;
         burst_cnt     <= '0;
      end else begin
         if (ad_ready) begin
            // dropped beats leave the register empty
            ilk_valid <= ad_valid & beat_keep;
         end
         if (ad_fire && beat_keep) begin
            ilk_burst_end <= burst_end;
            burst_cnt     <= burst_end ? '0 : cnt_sum;
         end
      end
   end

   // payload
   always_ff @(posedge clk) begin
      if (ad_fire && beat_keep) begin
         ilk_data      <= ad_data;
         ilk_num_valid <= ad_num_valid;
         ilk_sop       <= ad_sop;
         ilk_eopbits   <= ad_eopbits;
      end
   end

endmodule

// File: source/ilk_pkg.sv
/* shared widths and codes for the interlaken tx ingress path
   beat width is fixed at two 64-bit words, empty is a 4-bit byte count */

package ilk_pkg;

   // number of 64-bit words carried per avalon beat
   localparam int words_per_beat = 2;

   // a single 64-bit interlaken word
   typedef logic [63:0] word_t;

   // full beat, word 0 sits in the upper half (first on the wire)
   typedef logic [words_per_beat*$bits(word_t)-1:0] beat_data_t;

   // avalon empty, counts unused bytes at the low end of the beat
   typedef logic [3:0] empty_t;

   // valid words in a beat, 0 to 2
   typedef logic [1:0] num_valid_t;

   // interlaken eop code
   //   0000 no eop
   //   0001 eop with error
   //   1nnn eop, nnn = valid bytes in last word, 000 means 8
   typedef logic [3:0] eopbits_t;

   localparam eopbits_t eop_none  = 4'b0000;
   localparam eopbits_t eop_error = 4'b0001;

   // longest burst in words before a burst end is forced
   // small on purpose so short packets still cross it
   localparam int burst_max_words = 8;

   // word counter inside a burst, must hold burst_max_words itself
   typedef logic [$clog2(burst_max_words+1)-1:0] burst_count_t;

endpackage

// File: source/ilk_tx_top.sv
/* interlaken tx ingress, avalon-st in and burst-marked beats out
   two cycles of latency without stalls, no control words or crc here */

`timescale 1ns/1ps

module ilk_tx_top
   import ilk_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   // avalon-st sink
   input  beat_data_t avl_data,
   input  logic       avl_sop,
   input  logic       avl_eop,
   input  empty_t     avl_empty,
   input  logic       avl_error,
   input  logic       avl_valid,
   output logic       avl_ready,
   // interlaken beat source
   output beat_data_t ilk_data,
   output num_valid_t ilk_num_valid,
   output logic       ilk_sop,
   output eopbits_t   ilk_eopbits,
   output logic       ilk_burst_end,
   output logic       ilk_valid,
   input  logic       ilk_ready,
   // pulses once per discarded stray beat
   output logic       stray_drop
);

   // input stage to adapter
   beat_data_t rx_data;
   logic       rx_sop;
   logic       rx_eop;
   empty_t     rx_empty;
   logic       rx_error;
   logic       rx_valid;
   logic       rx_ready;

   // adapter to burst stage
   beat_data_t ad_data;
   num_valid_t ad_num_valid;
   logic       ad_sop;
   eopbits_t   ad_eopbits;
   logic       ad_valid;
   logic       ad_ready;

   avl_rx_stage u_rx (
      .clk        (clk),
      .reset      (reset),
      .avl_data   (avl_data),
      .avl_sop    (avl_sop),
      .avl_eop    (avl_eop),
      .avl_empty  (avl_empty),
      .avl_error  (avl_error),
      .avl_valid  (avl_valid),
      .avl_ready  (avl_ready),
      .rx_data    (rx_data),
      .rx_sop     (rx_sop),
      .rx_eop     (rx_eop),
      .rx_empty   (rx_empty),
      .rx_error   (rx_error),
      .rx_valid   (rx_valid),
      .rx_ready   (rx_ready),
      .stray_drop (stray_drop)
   );

   // ready passes back through unchanged
   avl_to_ilk_adapter u_adapter (
      .rx_data      (rx_data),
      .rx_sop       (rx_sop),
      .rx_eop       (rx_eop),
      .rx_empty     (rx_empty),
      .rx_error     (rx_error),
      .rx_valid     (rx_valid),
      .rx_ready     (rx_ready),
      .ad_data      (ad_data),
      .ad_num_valid (ad_num_valid),
      .ad_sop       (ad_sop),
      .ad_eopbits   (ad_eopbits),
      .ad_valid     (ad_valid),
      .ad_ready     (ad_ready)
   );

   ilk_burst_stage u_burst (
      .clk           (clk),
      .reset         (reset),
      .ad_data       (ad_data),
      .ad_num_valid  (ad_num_valid),
      .ad_sop        (ad_sop),
      .ad_eopbits    (ad_eopbits),
      .ad_valid      (ad_valid),
      .ad_ready      (ad_ready),
      .ilk_data      (ilk_data),
      .ilk_num_valid (ilk_num_valid),
      .ilk_sop       (ilk_sop),
      .ilk_eopbits   (ilk_eopbits),
      .ilk_burst_end (ilk_burst_end),
      .ilk_valid     (ilk_valid),
      .ilk_ready     (ilk_ready)
   );

endmodule

// File: vlog.f
source/ilk_pkg.sv
source/avl_rx_stage.sv
source/avl_to_ilk_adapter.sv
source/ilk_burst_stage.sv
source/ilk_tx_top.sv
bench/tb_ilk_tx.sv
